// File: Makefile
# Verilator build and run for the cartridge loader testbench

SIM := obj_dir/Vtb_cart_loader

.PHONY: all run clean

all: $(SIM)

$(SIM): filelist.f $(wildcard design/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cart_loader \
		-f filelist.f -o Vtb_cart_loader

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "Test failures found" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@grep -q "All tests passed!" sim.log || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: design/backup_ram_sequencer.sv
// Moves the backup RAM image one 512-byte sector at a time
// BK_SECTORS must be 2 or more; sd_lba is sized by its log2
// New triggers are ignored while an operation runs
// Carts with the SVP quirk never get backup RAM

`timescale 1ns/1ps

module backup_ram_sequencer import cart_pkg::*; #(
	parameter int BK_SECTORS = 128
) (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          dl_active,
	input  logic                          img_mounted,
	input  logic                          img_readonly,
	input  logic [63:0]                   img_size,
	input  quirk_flags_t                  quirks,
	input  logic                          bk_load,
	input  logic                          bk_save,
	input  logic                          sd_ack,
	output logic [$clog2(BK_SECTORS)-1:0] sd_lba,
	output logic                          sd_rd,
	output logic                          sd_wr,
	output logic                          bk_busy,
	output logic                          bk_loading,
	output logic                          bk_enabled
);

	localparam int LBA_W = $clog2(BK_SECTORS);
	localparam logic [LBA_W-1:0] LAST_LBA = LBA_W'(BK_SECTORS - 1);

	bk_state_t state;
	logic      dl_active_d;
	logic      load_d;
	logic      save_d;
	logic      ack_d;

	logic      load_rise;
	logic      save_rise;
	logic      ack_rise;
	logic      ack_fall;
	logic      dl_end;

	assign load_rise = bk_load && !load_d;
	assign save_rise = bk_save && !save_d;
	assign ack_rise  = sd_ack && !ack_d;
	assign ack_fall  = !sd_ack && ack_d;
	assign dl_end    = !dl_active && dl_active_d;
	assign bk_busy   = (state != BK_IDLE);

	////////////////////////////////////////////////////////////////////////////
	// Enable tracks the image while the cart is loading

	always_ff @(posedge clk_sys) begin
		if (reset)
			bk_enabled <= 1'b0;
		else if (dl_active && !dl_active_d)
			bk_enabled <= 1'b0;
		else if (dl_active)
			bk_enabled <= img_mounted && !img_readonly && !quirks.svp;
	end

	////////////////////////////////////////////////////////////////////////////
	// Sector FSM

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= BK_IDLE;
			dl_active_d <= 1'b0;
			load_d      <= 1'b0;
			save_d      <= 1'b0;
			ack_d       <= 1'b0;
			sd_lba      <= '0;
			sd_rd       <= 1'b0;
			sd_wr       <= 1'b0;
			bk_loading  <= 1'b0;
		end else begin
			dl_active_d <= dl_active;
			load_d      <= bk_load;
			save_d      <= bk_save;
			ack_d       <= sd_ack;
			case (state)
				BK_IDLE: begin
					if (bk_enabled && (load_rise || save_rise)) begin
						state      <= BK_REQUEST;
						bk_loading <= load_rise; // Load wins over save
						sd_lba     <= '0;
						sd_rd      <= load_rise;
						sd_wr      <= !load_rise;
					end else if (dl_end && bk_enabled && |img_size) begin
						state      <= BK_REQUEST; // Auto load after cart
						bk_loading <= 1'b1;
						sd_lba     <= '0;
						sd_rd      <= 1'b1;
						sd_wr      <= 1'b0;
					end
				end
				BK_REQUEST: begin
					if (ack_rise) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= BK_WAIT_DONE;
					end
				end
				BK_WAIT_DONE: begin
					if (ack_fall) begin
						if (sd_lba == LAST_LBA) begin
							state      <= BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							sd_lba <= sd_lba + 1'b1;
							sd_rd  <= bk_loading;
							sd_wr  <= !bk_loading;
							state  <= BK_REQUEST;
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr both high");

endmodule

// File: design/cart_header_parser.sv
// Watches accepted download words for the cartridge header fields
// Region letters are only taken from 0x1F0 (both bytes) and 0x1F2 (low byte)
// The product code is compared once, when the word at 0x18C arrives
// Flags and quirks are cleared at the start of every download

`timescale 1ns/1ps

module cart_header_parser import cart_pkg::*; (
	input  logic          clk_sys,
	input  logic          reset,
	input  logic          dl_active,
	input  logic          word_accept,
	input  dl_word_t      accepted_word,
	output region_flags_t hdr_flags,
	output logic          hdr_ready,
	output quirk_flags_t  quirks
);

	logic         dl_active_d;
	logic         dl_start;
	logic         dl_end;
	logic [63:0]  cart_id;
	quirk_flags_t id_match;
	logic [7:0]   lo_byte;
	logic [7:0]   hi_byte;

	assign dl_start = dl_active && !dl_active_d;
	assign dl_end   = !dl_active && dl_active_d;
	assign lo_byte  = accepted_word.data[7:0];
	assign hi_byte  = accepted_word.data[15:8];

	// One region letter to flags
	function automatic region_flags_t classify(input logic [7:0] c);
		region_flags_t f;
		f = '0;
		if (c == "J")
			f.j = 1'b1;
		else if (c == "U")
			f.u = 1'b1;
		else if (c >= "0" && c <= "Z")
			f.e = 1'b1; // Anything else printable counts as EU
		return f;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Product code table lookup

	always_comb begin
		logic found;
		found    = 1'b0;
		id_match = '0;
		for (int i = 0; i < QUIRK_COUNT; i++) begin
			if (!found && cart_id == QUIRK_TABLE[i].id) begin
				id_match = QUIRK_TABLE[i].flags;
				found    = 1'b1;
			end
		end
	end

	// Code bytes arrive swapped within each word
	always_ff @(posedge clk_sys) begin
		if (word_accept) begin
			case (accepted_word.addr)
				HDR_ID_FIRST:         cart_id[63:56] <= hi_byte;
				HDR_ID_FIRST + 25'd2: cart_id[55:40] <= {lo_byte, hi_byte};
				HDR_ID_FIRST + 25'd4: cart_id[39:24] <= {lo_byte, hi_byte};
				HDR_ID_FIRST + 25'd6: cart_id[23:8]  <= {lo_byte, hi_byte};
				HDR_ID_FIRST + 25'd8: cart_id[7:0]   <= lo_byte;
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Flags, header marker and quirks

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_active_d <= 1'b0;
			hdr_flags   <= '0;
			hdr_ready   <= 1'b0;
			quirks      <= '0;
		end else begin
			dl_active_d <= dl_active;
			if (dl_start) begin
				hdr_flags <= '0;
				quirks    <= '0;
			end
			if (dl_start || dl_end)
				hdr_ready <= 1'b0;

			if (word_accept) begin
				if (accepted_word.addr == HDR_REGION_A)
					hdr_flags <= hdr_flags | classify(lo_byte) | classify(hi_byte);
				if (accepted_word.addr == HDR_REGION_B)
					hdr_flags <= hdr_flags | classify(lo_byte);
				if (accepted_word.addr == HDR_ID_DECIDE)
					quirks <= quirks | id_match;
				if (accepted_word.addr == HDR_DONE)
					hdr_ready <= 1'b1;
			end
		end
	end

	a_one_quirk: assert property (@(posedge clk_sys) disable iff (reset)
		$countones(quirks & ~$past(quirks)) <= 1)
		else $error("more than one quirk raised by one decision");

endmodule

// File: design/cart_loader_top.sv
// Cartridge loading path with the ROM write bridge, header parser,
// region pick and backup RAM sequencer
// BK_SECTORS sets the save image length in 512-byte sectors

`timescale 1ns/1ps

module cart_loader_top import cart_pkg::*; #(
	parameter int BK_SECTORS = 128
) (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          dl_active,
	input  logic                          dl_valid,
	input  dl_word_t                      dl_word,
	output logic                          dl_ready,
	input  logic [7:0]                    dl_index,
	input  logic                          rom_ready,
	output logic                          rom_valid,
	output rom_write_t                    rom_wr,
	output logic [24:0]                   rom_size,
	input  region_source_t                source,
	input  region_order_t                 order,
	output region_t                       region,
	output logic                          region_set,
	output quirk_flags_t                  quirks,
	input  logic                          img_mounted,
	input  logic                          img_readonly,
	input  logic [63:0]                   img_size,
	input  logic                          bk_load,
	input  logic                          bk_save,
	input  logic                          sd_ack,
	output logic [$clog2(BK_SECTORS)-1:0] sd_lba,
	output logic                          sd_rd,
	output logic                          sd_wr,
	output logic                          bk_busy,
	output logic                          bk_loading,
	output logic                          bk_enabled
);

	logic          word_accept;
	dl_word_t      accepted_word;
	region_flags_t hdr_flags;
	logic          hdr_ready;

	rom_write_bridge bridge0 (.clk_sys, .reset, .dl_active, .dl_valid, .dl_word, .rom_ready,
		.dl_ready, .word_accept, .accepted_word, .rom_valid, .rom_wr, .rom_size);

	cart_header_parser parser0 (.clk_sys, .reset, .dl_active, .word_accept, .accepted_word,
		.hdr_flags, .hdr_ready, .quirks);

	region_selector region0 (.clk_sys, .reset, .hdr_flags, .hdr_ready, .source, .order,
		.dl_index, .region, .region_set);

	backup_ram_sequencer #(.BK_SECTORS(BK_SECTORS)) backup0 (.clk_sys, .reset, .dl_active,
		.img_mounted, .img_readonly, .img_size, .quirks, .bk_load, .bk_save, .sd_ack,
		.sd_lba, .sd_rd, .sd_wr, .bk_busy, .bk_loading, .bk_enabled);

endmodule

// File: design/cart_pkg.sv
// Shared types and constants for the cartridge loading path
// Download addresses are byte addresses of 16-bit words, always even
// Quirk table entries match the 8-character product code exactly

package cart_pkg;

	// Download word as it arrives from the host
	typedef struct packed {
		logic [24:0] addr;
		logic [15:0] data;
	} dl_word_t;

	// Word address plus byte-swapped data
	typedef struct packed {
		logic [23:0] addr;
		logic [15:0] data;
	} rom_write_t;

	typedef enum logic [1:0] {REGION_JP = 2'd0, REGION_US = 2'd1, REGION_EU = 2'd2} region_t;

	typedef struct packed {
		logic j;
		logic u;
		logic e;
	} region_flags_t;

	typedef enum logic [1:0] {
		ORDER_US_EU_JP, ORDER_EU_US_JP, ORDER_US_JP_EU, ORDER_JP_US_EU
	} region_order_t;

	typedef enum logic [1:0] {SRC_HEADER, SRC_INDEX, SRC_OFF} region_source_t;

	typedef struct packed {
		logic sram;
		logic eeprom;
		logic noram;
		logic fifo;
		logic pier;
		logic svp;
		logic fmbusy;
		logic schan;
	} quirk_flags_t;

	typedef enum logic [1:0] {BK_IDLE, BK_REQUEST, BK_WAIT_DONE} bk_state_t;

	////////////////////////////////////////////////////////////////////////////
	// Header offsets

	localparam logic [24:0] HDR_REGION_A  = 25'h1F0;
	localparam logic [24:0] HDR_REGION_B  = 25'h1F2;
	localparam logic [24:0] HDR_ID_FIRST  = 25'h182;
	localparam logic [24:0] HDR_ID_DECIDE = 25'h18C; // Code complete by here
	localparam logic [24:0] HDR_DONE      = 25'h200;

	////////////////////////////////////////////////////////////////////////////
	// Compatibility table

	typedef struct packed {
		logic [63:0]  id;
		quirk_flags_t flags;
	} quirk_entry_t;

	localparam quirk_flags_t Q_SRAM   = 8'h80;
	localparam quirk_flags_t Q_EEPROM = 8'h40;
	localparam quirk_flags_t Q_NORAM  = 8'h20;
	localparam quirk_flags_t Q_FIFO   = 8'h10;
	localparam quirk_flags_t Q_PIER   = 8'h08;
	localparam quirk_flags_t Q_SVP    = 8'h04;
	localparam quirk_flags_t Q_FMBUSY = 8'h02;
	localparam quirk_flags_t Q_SCHAN  = 8'h01;

	localparam int QUIRK_COUNT = 24;

	// First match wins
	localparam quirk_entry_t QUIRK_TABLE [QUIRK_COUNT] = '{
		'{"T-081276", Q_SRAM},   '{"T-81406 ", Q_SRAM},   '{"T-081586", Q_SRAM},
		'{"T-81576 ", Q_SRAM},   '{"T-81476 ", Q_SRAM},   '{"MK-1215 ", Q_EEPROM},
		'{"G-4060  ", Q_EEPROM}, '{"00001211", Q_EEPROM}, '{"MK-1228 ", Q_EEPROM},
		'{"G-5538  ", Q_EEPROM}, '{"00004076", Q_EEPROM}, '{"T-12046 ", Q_EEPROM},
		'{"T-12053 ", Q_EEPROM}, '{"G-4524  ", Q_EEPROM}, '{"T-113016", Q_NORAM},
		'{"T-89016 ", Q_FIFO},   '{"T-574023", Q_PIER},   '{"T-574013", Q_PIER},
		'{"MK-1229 ", Q_SVP},    '{"G-7001  ", Q_SVP},    '{"T-35036 ", Q_FMBUSY},
		'{"T-25073 ", Q_FMBUSY}, '{"MK-1137-", Q_FMBUSY}, '{"T-68???-", Q_SCHAN}
	};

endpackage

// File: design/region_selector.sv
// Picks the console region once per load, when the header marker is seen
// SRC_OFF leaves region and region_set untouched
// Index bits 7:6 are taken as the region code without a range check

`timescale 1ns/1ps

module region_selector import cart_pkg::*; (
	input  logic           clk_sys,
	input  logic           reset,
	input  region_flags_t  hdr_flags,
	input  logic           hdr_ready,
	input  region_source_t source,
	input  region_order_t  order,
	input  logic [7:0]     dl_index,
	output region_t        region,
	output logic           region_set
);

	logic hdr_ready_d;
	logic hdr_rise;
	logic hdr_fall;

	assign hdr_rise = hdr_ready && !hdr_ready_d;
	assign hdr_fall = !hdr_ready && hdr_ready_d;

	// First letter present in priority order, else first region of order
	function automatic region_t pick_region(input region_flags_t f, input region_order_t o);
		region_t r;
		r = REGION_US;
		case (o)
			ORDER_US_EU_JP: r = f.u ? REGION_US : f.e ? REGION_EU : f.j ? REGION_JP : REGION_US;
			ORDER_EU_US_JP: r = f.e ? REGION_EU : f.u ? REGION_US : f.j ? REGION_JP : REGION_EU;
			ORDER_US_JP_EU: r = f.u ? REGION_US : f.j ? REGION_JP : f.e ? REGION_EU : REGION_US;
			ORDER_JP_US_EU: r = f.j ? REGION_JP : f.u ? REGION_US : f.e ? REGION_EU : REGION_JP;
		endcase
		return r;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hdr_ready_d <= 1'b0;
			region      <= REGION_JP;
			region_set  <= 1'b0;
		end else begin
			hdr_ready_d <= hdr_ready;
			if (hdr_rise) begin
				if (source == SRC_HEADER) begin
					region     <= pick_region(hdr_flags, order);
					region_set <= 1'b1;
				end else if (source == SRC_INDEX) begin
					region     <= region_t'(dl_index[7:6]);
					region_set <= |dl_index; // Index 0 means no preference
				end
			end
			if (hdr_fall)
				region_set <= 1'b0;
		end
	end

endmodule

// File: design/rom_write_bridge.sv
// Download words pass through a single output register to the ROM port
// No new word is taken while that register is stalled by rom_ready
// rom_size is the byte address of the last word, valid after the load

`timescale 1ns/1ps

module rom_write_bridge import cart_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       dl_active,
	input  logic       dl_valid,
	input  dl_word_t   dl_word,
	input  logic       rom_ready,
	output logic       dl_ready,
	output logic       word_accept,
	output dl_word_t   accepted_word,
	output logic       rom_valid,
	output rom_write_t rom_wr,
	output logic [24:0] rom_size
);

	logic        dl_active_d;
	logic [24:0] last_addr;

	// Register empty, or draining this cycle
	assign dl_ready      = !rom_valid || rom_ready;
	assign word_accept   = dl_active && dl_valid && dl_ready;
	assign accepted_word = dl_word;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_valid   <= 1'b0;
			dl_active_d <= 1'b0;
			rom_size    <= '0;
		end else begin
			dl_active_d <= dl_active;
			if (word_accept)
				rom_valid <= 1'b1;
			else if (rom_ready)
				rom_valid <= 1'b0;
			if (dl_active_d && !dl_active)
				rom_size <= last_addr; // End of load
		end
	end

	// Payload, halved address and swapped bytes
	always_ff @(posedge clk_sys) begin
		if (word_accept) begin
			rom_wr.addr <= dl_word.addr[24:1];
			rom_wr.data <= {dl_word.data[7:0], dl_word.data[15:8]};
			last_addr   <= dl_word.addr;
		end
	end

	a_rom_hold: assert property (@(posedge clk_sys) disable iff (reset)
		(rom_valid && !rom_ready) |=> (rom_valid && $stable(rom_wr)))
		else $error("rom_wr changed while stalled");

endmodule

// File: filelist.f
design/cart_pkg.sv
design/rom_write_bridge.sv
design/cart_header_parser.sv
design/region_selector.sv
design/backup_ram_sequencer.sv
design/cart_loader_top.sv
testbench/tb_cart_loader.sv

// File: testbench/tb_cart_loader.sv
// Testbench for the cartridge loading path with BK_SECTORS = 4
// Five downloads of 300 words each, rom_ready toggled at random
// The sector host answers each request after a random 1 to 5 cycles
// Header checks are sampled on the cycle where dl_active falls

`timescale 1ns/1ps

module tb_cart_loader import cart_pkg::*; ();

	localparam int     BK_SECTORS  = 4;
	localparam int     LOAD_WORDS  = 300; // Covers the header up to 0x256
	localparam longint WATCHDOG_NS = 5 * (600 + 40) * 8 * 4;

	logic           clk_sys;
	logic           reset;
	logic           dl_active;
	logic           dl_valid;
	dl_word_t       dl_word;
	logic           dl_ready;
	logic [7:0]     dl_index;
	logic           rom_ready;
	logic           rom_valid;
	rom_write_t     rom_wr;
	logic [24:0]    rom_size;
	region_source_t source;
	region_order_t  order;
	region_t        region;
	logic           region_set;
	quirk_flags_t   quirks;
	logic           img_mounted;
	logic           img_readonly;
	logic [63:0]    img_size;
	logic           bk_load;
	logic           bk_save;
	logic           sd_ack;
	logic [1:0]     sd_lba;
	logic           sd_rd;
	logic           sd_wr;
	logic           bk_busy;
	logic           bk_loading;
	logic           bk_enabled;

	rom_write_t     rom_q [$];    // Expected ROM writes in order
	logic [2:0]     sector_q [$]; // Observed requests as {write, lba}
	logic [24:0]    last_addr;
	region_t        exp_region;
	logic           exp_set;
	quirk_flags_t   exp_quirks;
	logic           exp_enabled;

	cart_loader_top #(.BK_SECTORS(BK_SECTORS)) dut0 (.*);

	always #4 clk_sys = ~clk_sys;

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] want);
		$display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, name, got, want);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic report_error(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		$display("Test failures found");
		$fatal(1);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Cartridge image with one byte per ROM address

	function automatic logic [7:0] rom_byte(input logic [24:0] a, input int cart);
		logic [63:0] code;
		int          idx;
		code = (cart == 0) ? "T-081276" : "MK-1229 ";
		idx  = 32'h18A - int'(a);
		if (a >= 25'h183 && a <= 25'h18A)
			return code[idx * 8 +: 8]; // Product code starts at 0x183
		if (a == 25'h1F0)
			return (cart == 0) ? "U" : " ";
		if (a == 25'h1F2)
			return (cart == 0) ? "E" : " ";
		if (a == 25'h1F1 || a == 25'h1F3)
			return " ";
		return 8'(a ^ (a >> 8) ^ (a >> 16) ^ (a >> 24)) ^ 8'(cart);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus tasks

	task automatic run_load(input int cart, input logic [7:0] index, input logic mounted);
		logic [24:0] addr;
		@(posedge clk_sys);
		#1;
		dl_index    = index;
		img_mounted = mounted;
		dl_active   = 1'b1;
		for (int i = 0; i < LOAD_WORDS; i++) begin
			addr          = 25'(2 * i);
			dl_word.addr  = addr;
			dl_word.data  = {rom_byte(addr + 25'd1, cart), rom_byte(addr, cart)};
			dl_valid      = 1'b1;
			@(negedge clk_sys);
			while (!dl_ready)
				@(negedge clk_sys);
			// Taken at the coming edge
			rom_q.push_back({addr[24:1], rom_byte(addr, cart), rom_byte(addr + 25'd1, cart)});
			last_addr = addr;
			@(posedge clk_sys);
			#1;
		end
		dl_valid = 1'b0;
		@(posedge clk_sys);
		#1;
		dl_active = 1'b0;
		repeat (4) @(posedge clk_sys);
		#1;
	endtask

	task automatic wait_backup_done();
		wait (bk_busy);
		wait (!bk_busy);
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_sectors(input logic write);
		logic [2:0] req;
		if (sector_q.size() != BK_SECTORS)
			report_error($sformatf("expected %0d sector requests, saw %0d",
				BK_SECTORS, sector_q.size()));
		for (int i = 0; i < BK_SECTORS; i++) begin
			req = sector_q.pop_front();
			if (req[2] != write)
				report_mismatch("sd request type", req[2], write);
			if (req[1:0] != 2'(i))
				report_mismatch("sd_lba", req[1:0], i);
		end
	endtask

	task automatic check_idle();
		repeat (20) @(posedge clk_sys);
		#1;
		if (sector_q.size() != 0 || bk_busy)
			report_error("backup RAM activity where none was expected");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Responders and checkers

	always @(posedge clk_sys) begin
		#1;
		rom_ready = ($urandom_range(0, 1) == 1);
	end

	// Sector host
	always begin
		@(negedge clk_sys);
		if (!reset && (sd_rd || sd_wr) && !sd_ack) begin
			sector_q.push_back({sd_wr, sd_lba});
			repeat ($urandom_range(1, 5)) @(posedge clk_sys);
			#1;
			sd_ack = 1'b1;
			repeat (2) @(posedge clk_sys);
			#1;
			sd_ack = 1'b0;
		end
	end

	always @(negedge clk_sys) begin
		rom_write_t want;
		if (!reset && rom_valid && rom_ready) begin // Completes at the next edge
			if (rom_q.size() == 0) begin
				report_error("ROM write with no download word pending");
			end else begin
				want = rom_q.pop_front();
				if (rom_wr != want)
					report_mismatch("rom_wr", rom_wr, want);
			end
		end
	end

	// No download word is taken while the output register is stalled
	a_dl_ready: assert property (@(posedge clk_sys) disable iff (reset)
		(!rom_valid |-> dl_ready) and ((rom_valid && !rom_ready) |-> !dl_ready))
		else report_mismatch("dl_ready", $sampled(dl_ready), $sampled(!rom_valid));

	a_rom_size: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(dl_active) |=> rom_size == last_addr)
		else report_mismatch("rom_size", $sampled(rom_size), $sampled(last_addr));

	a_region_set: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(dl_active) |-> region_set == exp_set)
		else report_mismatch("region_set", $sampled(region_set), exp_set);

	a_region: assert property (@(posedge clk_sys) disable iff (reset)
		($fell(dl_active) && exp_set) |-> region == exp_region)
		else report_mismatch("region", $sampled(region), exp_region);

	a_quirks: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(dl_active) |-> quirks == exp_quirks)
		else report_mismatch("quirks", $sampled(quirks), exp_quirks);

	a_bk_enabled: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(dl_active) |-> bk_enabled == exp_enabled)
		else report_mismatch("bk_enabled", $sampled(bk_enabled), exp_enabled);

	a_rd_wr: assert property (@(posedge clk_sys) disable iff (reset) !(sd_rd && sd_wr))
		else report_error("sd_rd and sd_wr high together");

	a_rd_loading: assert property (@(posedge clk_sys) disable iff (reset)
		(sd_rd |-> bk_loading) and (sd_wr |-> !bk_loading))
		else report_mismatch("bk_loading", $sampled(bk_loading), $sampled(sd_rd));

	// Loading flag holds until the whole image is done
	a_loading_end: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(bk_loading) |-> $fell(bk_busy))
		else report_error("bk_loading fell before the operation ended");

	initial begin
		#(WATCHDOG_NS);
		report_error("watchdog timeout, the run did not finish");
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		void'($urandom(65));
		clk_sys      = 1'b0;
		reset        = 1'b1;
		dl_active    = 1'b0;
		dl_valid     = 1'b0;
		dl_word      = '0;
		dl_index     = 8'h00;
		rom_ready    = 1'b0;
		source       = SRC_HEADER;
		order        = ORDER_US_EU_JP;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size     = 64'h0;
		bk_load      = 1'b0;
		bk_save      = 1'b0;
		sd_ack       = 1'b0;
		last_addr    = '0;
		exp_region   = REGION_JP;
		exp_set      = 1'b0;
		exp_quirks   = '0;
		exp_enabled  = 1'b0;
		repeat (16) @(posedge clk_sys);
		#1;
		reset    = 1'b0;
		img_size = 64'h10000;

		// U and E in the header with EU first
		order            = ORDER_EU_US_JP;
		exp_region       = REGION_EU;
		exp_set          = 1'b1;
		exp_quirks.sram  = 1'b1;
		exp_enabled      = 1'b1;
		run_load(0, 8'h00, 1'b1);
		wait_backup_done(); // Auto load
		check_sectors(1'b0);
		bk_save = 1'b1;
		repeat (2) @(posedge clk_sys);
		#1;
		bk_save = 1'b0;
		wait_backup_done();
		check_sectors(1'b1);

		order       = ORDER_US_JP_EU;
		exp_region  = REGION_US;
		exp_enabled = 1'b0;
		run_load(0, 8'h00, 1'b0);
		check_idle();

		// SVP cart with no letters and the image mounted
		order           = ORDER_JP_US_EU;
		exp_region      = REGION_JP;
		exp_quirks      = '0;
		exp_quirks.svp  = 1'b1;
		run_load(1, 8'h00, 1'b1);
		check_idle();

		source          = SRC_INDEX;
		exp_region      = REGION_EU;
		exp_quirks      = '0;
		exp_quirks.sram = 1'b1;
		run_load(0, 8'h80, 1'b0);
		check_idle();

		exp_set = 1'b0; // Index 0 gives no region
		run_load(0, 8'h00, 1'b0);
		check_idle();

		if (rom_q.size() != 0) begin
			report_error($sformatf("%0d download words never reached the ROM port",
				rom_q.size()));
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule
